// File: all.f
hdl/rr_pkg.sv
hdl/uop_if.sv
hdl/wb_if.sv
hdl/tagged_reg_file.sv
hdl/operand_read.sv
hdl/int_execute.sv
hdl/pipe_ctrl.sv
hdl/rr_core_top.sv
dv/rr_core_asserts.sv
dv/rr_core_tb.sv

// File: dv/rr_core_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module rr_core_asserts (
    input wire logic clk_i,
    input wire logic rstn_i,
    input wire logic issue_valid_i,
    input wire logic issue_ready_o,
    input wire logic res_valid_o
);

    int unsigned err_count = 0;
    logic        issue_fire;

    assign issue_fire = issue_valid_i && issue_ready_o;

    // Result valid is cleared by the synchronous reset.
    a_quiet_in_reset: assert property (@(posedge clk_i) !rstn_i |=> !res_valid_o)
        else begin
            err_count++;
            $error("res_valid_o is high while in reset");
        end

    // With nothing accepted lately, no destination can still be pending.
    a_ready_when_idle: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !$past(issue_fire, 1) && !$past(issue_fire, 2) |-> issue_ready_o)
        else begin
            err_count++;
            $error("issue_ready_o is low although nothing is in flight");
        end

endmodule

bind rr_core_top rr_core_asserts asserts0 (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .issue_valid_i (issue_valid_i),
    .issue_ready_o (issue_ready_o),
    .res_valid_o   (res_valid_o)
);

`default_nettype wire

// File: dv/rr_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rr_core_tb;

    localparam int N_ISSUE        = 300;
    // Each issue needs at most a gap, two stall cycles and the accepting cycle.
    localparam int TIMEOUT_CYCLES = N_ISSUE * 4 + 50;

    logic              clk_i;
    logic              rstn_i;
    logic              issue_valid_i;
    logic              issue_ready_o;
    rr_pkg::alu_op_e   issue_op_i;
    rr_pkg::reg_addr_t issue_rd_i;
    rr_pkg::reg_addr_t issue_rs1_i;
    rr_pkg::reg_addr_t issue_rs2_i;
    logic              issue_use_imm_i;
    rr_pkg::data_t     issue_imm_i;
    rr_pkg::pc_t       issue_pc_i;
    logic              res_valid_o;
    rr_pkg::reg_addr_t res_rd_o;
    rr_pkg::data_t     res_data_o;
    rr_pkg::pc_t       res_pc_o;

    int                seed = 48;
    rr_pkg::data_t     model_regs [rr_pkg::NUM_REGS];
    rr_pkg::reg_addr_t exp_rd_q [$];
    rr_pkg::data_t     exp_data_q [$];
    rr_pkg::pc_t       exp_pc_q [$];
    rr_pkg::reg_addr_t front_rd = '0;
    rr_pkg::data_t     front_data = '0;
    rr_pkg::pc_t       front_pc = '0;
    logic              q_empty = 1'b1;
    logic              ready_low_seen = 1'b0;
    rr_pkg::data_t     op_b;

    rr_core_top dut0 (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .issue_valid_i   (issue_valid_i),
        .issue_ready_o   (issue_ready_o),
        .issue_op_i      (issue_op_i),
        .issue_rd_i      (issue_rd_i),
        .issue_rs1_i     (issue_rs1_i),
        .issue_rs2_i     (issue_rs2_i),
        .issue_use_imm_i (issue_use_imm_i),
        .issue_imm_i     (issue_imm_i),
        .issue_pc_i      (issue_pc_i),
        .res_valid_o     (res_valid_o),
        .res_rd_o        (res_rd_o),
        .res_data_o      (res_data_o),
        .res_pc_o        (res_pc_o)
    );

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return int'($unsigned(r) % $unsigned(n));
    endfunction

    // Reference ALU. Shifts take the low five bits of the second operand.
    function automatic rr_pkg::data_t alu_model(input rr_pkg::alu_op_e op,
                                                input rr_pkg::data_t a,
                                                input rr_pkg::data_t b);
        case (op)
            rr_pkg::ALU_ADD: return a + b;
            rr_pkg::ALU_SUB: return a - b;
            rr_pkg::ALU_AND: return a & b;
            rr_pkg::ALU_OR:  return a | b;
            rr_pkg::ALU_XOR: return a ^ b;
            rr_pkg::ALU_SLL: return a << b[4:0];
            rr_pkg::ALU_SRL: return a >> b[4:0];
            default:         return '0;
        endcase
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        fail_run($sformatf("error %s: expected %h, actual %h", name, exp_val, act_val));
    endtask

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_i);
        fail_run("timeout: results stopped arriving before every issue retired");
    end

    // Model register file, updated in issue order on each accepted issue.
    always @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < rr_pkg::NUM_REGS; i++) begin
                model_regs[i] = '0;
            end
        end else begin
            if (res_valid_o && exp_data_q.size() != 0) begin
                void'(exp_rd_q.pop_front());
                void'(exp_data_q.pop_front());
                void'(exp_pc_q.pop_front());
            end
            if (issue_valid_i && issue_ready_o) begin
                op_b = issue_use_imm_i ? issue_imm_i : model_regs[issue_rs2_i];
                exp_rd_q.push_back(issue_rd_i);
                exp_data_q.push_back(alu_model(issue_op_i, model_regs[issue_rs1_i], op_b));
                exp_pc_q.push_back(issue_pc_i);
                if (issue_rd_i != '0) begin
                    model_regs[issue_rd_i] = exp_data_q[$];
                end
            end
        end
        q_empty <= (exp_data_q.size() == 0);
        if (exp_data_q.size() != 0) begin
            front_rd   <= exp_rd_q[0];
            front_data <= exp_data_q[0];
            front_pc   <= exp_pc_q[0];
        end
    end

    always @(negedge clk_i) begin
        if (rstn_i && !issue_ready_o) begin
            ready_low_seen <= 1'b1;
        end
        if (dut0.asserts0.err_count != 0) begin
            fail_run("a protocol assertion bound to rr_core_top failed");
        end
    end

    a_reset_state: assert property (@(posedge clk_i)
        $rose(rstn_i) |-> !res_valid_o && issue_ready_o)
        else fail_run("res_valid_o or issue_ready_o is wrong right after reset");

    a_no_extra: assert property (@(posedge clk_i) disable iff (!rstn_i)
        res_valid_o |-> !q_empty)
        else fail_run("a result arrived while no issue was outstanding");

    a_res_rd: assert property (@(posedge clk_i) disable iff (!rstn_i)
        res_valid_o && !q_empty |-> res_rd_o == front_rd)
        else report_mismatch("result_rd", 32'(front_rd), 32'(res_rd_o));

    a_res_data: assert property (@(posedge clk_i) disable iff (!rstn_i)
        res_valid_o && !q_empty |-> res_data_o == front_data)
        else report_mismatch("result_data", front_data, res_data_o);

    a_res_pc: assert property (@(posedge clk_i) disable iff (!rstn_i)
        res_valid_o && !q_empty |-> res_pc_o == front_pc)
        else report_mismatch("result_pc", front_pc, res_pc_o);

    initial begin
        rr_pkg::reg_addr_t prev_rd;
        rstn_i          = 1'b0;
        issue_valid_i   = 1'b0;
        issue_op_i      = rr_pkg::ALU_ADD;
        issue_rd_i      = '0;
        issue_rs1_i     = '0;
        issue_rs2_i     = '0;
        issue_use_imm_i = 1'b0;
        issue_imm_i     = '0;
        issue_pc_i      = '0;
        prev_rd         = '0;
        repeat (3) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;
        for (int i = 0; i < N_ISSUE; i++) begin
            if (rand_below(4) == 0) begin
                issue_valid_i = 1'b0;
                @(posedge clk_i);
                #1;
            end
            issue_op_i      = rr_pkg::alu_op_e'(rand_below(7));
            issue_rd_i      = (rand_below(8) == 0) ? '0 : rr_pkg::reg_addr_t'(rand_below(32));
            // Half of the sources read the previous destination to force RAW hazards.
            issue_rs1_i     = (rand_below(2) == 0) ? prev_rd : rr_pkg::reg_addr_t'(rand_below(32));
            issue_rs2_i     = (rand_below(2) == 0) ? prev_rd : rr_pkg::reg_addr_t'(rand_below(32));
            issue_use_imm_i = (rand_below(2) == 0);
            issue_imm_i     = $random(seed);
            issue_pc_i      = 32'h0000_1000 + 32'(i * 4);
            issue_valid_i   = 1'b1;
            @(negedge clk_i);
            while (!issue_ready_o) @(negedge clk_i);
            @(posedge clk_i);
            #1;
            prev_rd = issue_rd_i;
        end
        issue_valid_i = 1'b0;
        while (exp_data_q.size() != 0) @(posedge clk_i);
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        if (ready_low_seen && dut0.asserts0.err_count == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else if (!ready_low_seen) begin
            fail_run("issue_ready_o was never low, so no operand stall was exercised");
        end else begin
            fail_run("a protocol assertion failed at the end of the run");
        end
    end

endmodule

`default_nettype wire

// File: hdl/int_execute.sv
`timescale 1ns/1ps
`default_nettype none

module int_execute (
    input  wire logic         clk_i,
    input  wire logic         rstn_i,

    uop_if.consumer           uop_i,

    wb_if.source              wb_o,
    output rr_pkg::pc_t       res_pc_o
);

    rr_pkg::data_t                  op_a;
    rr_pkg::data_t                  op_b;
    rr_pkg::data_t                  result;
    logic [rr_pkg::SHAMT_W-1:0]     shamt;

    assign op_a  = uop_i.rs1_data;
    assign op_b  = uop_i.use_imm ? uop_i.imm : uop_i.rs2_data;
    assign shamt = op_b[rr_pkg::SHAMT_W-1:0];

    always_comb begin
        case (uop_i.op)
            rr_pkg::ALU_ADD: result = op_a + op_b;
            rr_pkg::ALU_SUB: result = op_a - op_b;
            rr_pkg::ALU_AND: result = op_a & op_b;
            rr_pkg::ALU_OR:  result = op_a | op_b;
            rr_pkg::ALU_XOR: result = op_a ^ op_b;
            rr_pkg::ALU_SLL: result = op_a << shamt;
            rr_pkg::ALU_SRL: result = op_a >> shamt;
            default:         result = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wb_o.valid <= 1'b0;
        end else begin
            wb_o.valid <= uop_i.valid;
        end
    end

    // Result payload, qualified by wb_o.valid.
    always_ff @(posedge clk_i) begin
        wb_o.rd   <= uop_i.rd;
        wb_o.tag  <= uop_i.tag;
        wb_o.data <= result;
        res_pc_o  <= uop_i.pc;
    end

endmodule

`default_nettype wire

// File: hdl/operand_read.sv
`timescale 1ns/1ps
`default_nettype none

module operand_read (
    input  wire logic              clk_i,
    input  wire logic              rstn_i,

    uop_if.consumer                uop_i,
    uop_if.producer                uop_o,

    output rr_pkg::reg_addr_t      rd_addr1_o,
    output rr_pkg::reg_addr_t      rd_addr2_o,
    input  wire rr_pkg::data_t     rd_data1_i,
    input  wire rr_pkg::data_t     rd_data2_i,
    input  wire logic              rd_ready1_i,
    input  wire logic              rd_ready2_i,

    output logic                   claim_valid_o,
    output rr_pkg::reg_addr_t      claim_addr_o,
    output rr_pkg::tag_t           claim_tag_o,

    output logic                   stall_o
);

    logic src_pending;

    assign rd_addr1_o = uop_i.rs1;
    assign rd_addr2_o = uop_i.rs2;

    assign src_pending = (uop_i.rs1_en && !rd_ready1_i) || (uop_i.rs2_en && !rd_ready2_i);
    assign stall_o     = uop_i.valid && src_pending;

    // Destination is claimed only when the micro-op moves on.
    assign claim_valid_o = uop_i.valid && !stall_o;
    assign claim_addr_o  = uop_i.rd;
    assign claim_tag_o   = uop_i.tag;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            uop_o.valid <= 1'b0;
        end else begin
            uop_o.valid <= uop_i.valid && !stall_o;
        end
    end

    always_ff @(posedge clk_i) begin
        uop_o.pc       <= uop_i.pc;
        uop_o.op       <= uop_i.op;
        uop_o.rd       <= uop_i.rd;
        uop_o.rs1      <= uop_i.rs1;
        uop_o.rs2      <= uop_i.rs2;
        uop_o.rs1_en   <= uop_i.rs1_en;
        uop_o.rs2_en   <= uop_i.rs2_en;
        uop_o.use_imm  <= uop_i.use_imm;
        uop_o.imm      <= uop_i.imm;
        uop_o.tag      <= uop_i.tag;
        uop_o.rs1_data <= rd_data1_i;
        uop_o.rs2_data <= rd_data2_i;
    end

endmodule

`default_nettype wire

// File: hdl/pipe_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl (
    input  wire logic              clk_i,
    input  wire logic              rstn_i,

    input  wire logic              issue_valid_i,
    output logic                   issue_ready_o,
    input  wire rr_pkg::alu_op_e   issue_op_i,
    input  wire rr_pkg::reg_addr_t issue_rd_i,
    input  wire rr_pkg::reg_addr_t issue_rs1_i,
    input  wire rr_pkg::reg_addr_t issue_rs2_i,
    input  wire logic              issue_use_imm_i,
    input  wire rr_pkg::data_t     issue_imm_i,
    input  wire rr_pkg::pc_t       issue_pc_i,

    input  wire logic              stall_i,
    uop_if.producer                uop_o
);

    rr_pkg::tag_t tag_q;
    logic         issue_fire;

    assign issue_ready_o = !stall_i;
    assign issue_fire    = issue_valid_i && issue_ready_o;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            tag_q <= '0;
        end else if (issue_fire) begin
            tag_q <= tag_q + 1'b1;
        end
    end

    assign uop_o.valid   = issue_valid_i;
    assign uop_o.pc      = issue_pc_i;
    assign uop_o.op      = issue_op_i;
    assign uop_o.rd      = issue_rd_i;
    assign uop_o.rs1     = issue_rs1_i;
    assign uop_o.rs2     = issue_rs2_i;
    assign uop_o.use_imm = issue_use_imm_i;
    assign uop_o.imm     = issue_imm_i;
    assign uop_o.tag     = tag_q;

    // rs1 is always read. rs2 only without an immediate.
    assign uop_o.rs1_en  = 1'b1;
    assign uop_o.rs2_en  = !issue_use_imm_i;

    // Operand values are filled in by the read stage.
    assign uop_o.rs1_data = '0;
    assign uop_o.rs2_data = '0;

endmodule

`default_nettype wire

// File: hdl/rr_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rr_core_top (
    input  wire logic              clk_i,
    input  wire logic              rstn_i,

    input  wire logic              issue_valid_i,
    output logic                   issue_ready_o,
    input  wire rr_pkg::alu_op_e   issue_op_i,
    input  wire rr_pkg::reg_addr_t issue_rd_i,
    input  wire rr_pkg::reg_addr_t issue_rs1_i,
    input  wire rr_pkg::reg_addr_t issue_rs2_i,
    input  wire logic              issue_use_imm_i,
    input  wire rr_pkg::data_t     issue_imm_i,
    input  wire rr_pkg::pc_t       issue_pc_i,

    output logic                   res_valid_o,
    output rr_pkg::reg_addr_t      res_rd_o,
    output rr_pkg::data_t          res_data_o,
    output rr_pkg::pc_t            res_pc_o
);

    uop_if ctrl_uop ();
    uop_if exe_uop ();
    wb_if  wb ();

    logic              stall;
    rr_pkg::reg_addr_t rd_addr1;
    rr_pkg::reg_addr_t rd_addr2;
    rr_pkg::data_t     rd_data1;
    rr_pkg::data_t     rd_data2;
    logic              rd_ready1;
    logic              rd_ready2;
    logic              claim_valid;
    rr_pkg::reg_addr_t claim_addr;
    rr_pkg::tag_t      claim_tag;

    pipe_ctrl ctrl0 (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .issue_valid_i   (issue_valid_i),
        .issue_ready_o   (issue_ready_o),
        .issue_op_i      (issue_op_i),
        .issue_rd_i      (issue_rd_i),
        .issue_rs1_i     (issue_rs1_i),
        .issue_rs2_i     (issue_rs2_i),
        .issue_use_imm_i (issue_use_imm_i),
        .issue_imm_i     (issue_imm_i),
        .issue_pc_i      (issue_pc_i),
        .stall_i         (stall),
        .uop_o           (ctrl_uop)
    );

    operand_read rr0 (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .uop_i         (ctrl_uop),
        .uop_o         (exe_uop),
        .rd_addr1_o    (rd_addr1),
        .rd_addr2_o    (rd_addr2),
        .rd_data1_i    (rd_data1),
        .rd_data2_i    (rd_data2),
        .rd_ready1_i   (rd_ready1),
        .rd_ready2_i   (rd_ready2),
        .claim_valid_o (claim_valid),
        .claim_addr_o  (claim_addr),
        .claim_tag_o   (claim_tag),
        .stall_o       (stall)
    );

    tagged_reg_file rf0 (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .rd_addr1_i    (rd_addr1),
        .rd_addr2_i    (rd_addr2),
        .rd_data1_o    (rd_data1),
        .rd_data2_o    (rd_data2),
        .rd_ready1_o   (rd_ready1),
        .rd_ready2_o   (rd_ready2),
        .claim_valid_i (claim_valid),
        .claim_addr_i  (claim_addr),
        .claim_tag_i   (claim_tag),
        .wb_i          (wb)
    );

    int_execute exe0 (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .uop_i    (exe_uop),
        .wb_o     (wb),
        .res_pc_o (res_pc_o)
    );

    // Results leave straight from the writeback broadcast.
    assign res_valid_o = wb.valid;
    assign res_rd_o    = wb.rd;
    assign res_data_o  = wb.data;

endmodule

`default_nettype wire

// File: hdl/rr_pkg.sv
`default_nettype none

package rr_pkg;

    localparam int DATA_W     = 32;
    localparam int PC_W       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int TAG_W      = 4;
    localparam int ALU_OP_W   = 3;
    localparam int NUM_REGS   = 32;

    // Shift amount taken from the low bits of the second operand.
    localparam int SHAMT_W    = 5;

    // Operand and result value.
    typedef logic [DATA_W-1:0] data_t;

    // Instruction address carried along with each micro-op.
    typedef logic [PC_W-1:0] pc_t;

    // Register index. Register 0 always reads zero.
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Rolling tag of an in-flight micro-op.
    typedef logic [TAG_W-1:0] tag_t;

    typedef enum logic [ALU_OP_W-1:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6
    } alu_op_e;

endpackage

`default_nettype wire

// File: hdl/tagged_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module tagged_reg_file (
    input  wire logic              clk_i,
    input  wire logic              rstn_i,

    input  wire rr_pkg::reg_addr_t rd_addr1_i,
    input  wire rr_pkg::reg_addr_t rd_addr2_i,
    output rr_pkg::data_t          rd_data1_o,
    output rr_pkg::data_t          rd_data2_o,
    output logic                   rd_ready1_o,
    output logic                   rd_ready2_o,

    input  wire logic              claim_valid_i,
    input  wire rr_pkg::reg_addr_t claim_addr_i,
    input  wire rr_pkg::tag_t      claim_tag_i,

    wb_if.sink                     wb_i
);

    rr_pkg::data_t     regs_q [rr_pkg::NUM_REGS];
    logic              pend_q [rr_pkg::NUM_REGS];
    rr_pkg::tag_t      tag_q  [rr_pkg::NUM_REGS];

    rr_pkg::reg_addr_t rd_addr  [2];
    rr_pkg::data_t     rd_data  [2];
    logic              rd_ready [2];

    assign rd_addr[0] = rd_addr1_i;
    assign rd_addr[1] = rd_addr2_i;

    // Both read ports share the same lookup with writeback forwarding.
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            if (rd_addr[p] == '0) begin
                rd_data[p]  = '0;
                rd_ready[p] = 1'b1;
            end else if (wb_i.valid && wb_i.rd == rd_addr[p] && pend_q[rd_addr[p]] &&
                         wb_i.tag == tag_q[rd_addr[p]]) begin
                rd_data[p]  = wb_i.data;
                rd_ready[p] = 1'b1;
            end else begin
                rd_data[p]  = regs_q[rd_addr[p]];
                rd_ready[p] = !pend_q[rd_addr[p]];
            end
        end
    end

    assign rd_data1_o  = rd_data[0];
    assign rd_data2_o  = rd_data[1];
    assign rd_ready1_o = rd_ready[0];
    assign rd_ready2_o = rd_ready[1];

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < rr_pkg::NUM_REGS; i++) begin
                regs_q[i] <= '0;
                pend_q[i] <= 1'b0;
            end
        end else begin
            if (wb_i.valid && wb_i.rd != '0) begin
                regs_q[wb_i.rd] <= wb_i.data;
                // Only the youngest writer releases the register.
                if (wb_i.tag == tag_q[wb_i.rd]) begin
                    pend_q[wb_i.rd] <= 1'b0;
                end
            end
            // A new claim wins over a clear in the same cycle.
            if (claim_valid_i && claim_addr_i != '0) begin
                pend_q[claim_addr_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (claim_valid_i && claim_addr_i != '0) begin
            tag_q[claim_addr_i] <= claim_tag_i;
        end
    end

endmodule

`default_nettype wire

// File: hdl/uop_if.sv
`timescale 1ns/1ps
`default_nettype none

interface uop_if;

    logic              valid;
    rr_pkg::pc_t       pc;
    rr_pkg::alu_op_e   op;
    rr_pkg::reg_addr_t rd;
    rr_pkg::reg_addr_t rs1;
    rr_pkg::reg_addr_t rs2;
    logic              rs1_en;
    logic              rs2_en;
    logic              use_imm;
    rr_pkg::data_t     imm;
    rr_pkg::tag_t      tag;
    // Operand values, filled in by the register-read stage.
    rr_pkg::data_t     rs1_data;
    rr_pkg::data_t     rs2_data;

    modport producer (
        output valid, pc, op, rd, rs1, rs2, rs1_en, rs2_en,
        output use_imm, imm, tag, rs1_data, rs2_data
    );

    modport consumer (
        input valid, pc, op, rd, rs1, rs2, rs1_en, rs2_en,
        input use_imm, imm, tag, rs1_data, rs2_data
    );

endinterface

`default_nettype wire

// File: hdl/wb_if.sv
`timescale 1ns/1ps
`default_nettype none

interface wb_if;

    logic              valid;
    rr_pkg::reg_addr_t rd;
    rr_pkg::tag_t      tag;
    rr_pkg::data_t     data;

    modport source (
        output valid, rd, tag, data
    );

    modport sink (
        input valid, rd, tag, data
    );

endinterface

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build and run the rr_core testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -f all.f --top-module rr_core_tb \
        -Mdir obj_dir -o rr_core_sim; then
    echo "Verilator build failed"
    exit 1
fi

obj_dir/rr_core_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "ALL CHECKS PASSED" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
